// File: filelist.f
src/spi_pkg.sv
src/spi_char_if.sv
src/spi_word_fifo.sv
src/spi_regs.sv
src/spi_frame_ctrl.sv
src/spi_bit_engine.sv
src/spi_master_top.sv
test/tb_spi_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run into sim.log, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_spi_master -f filelist.f \
    && ./obj_dir/Vtb_spi_master > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: src/spi_bit_engine.sv
`timescale 1ns/1ps

module spi_bit_engine (
    input  logic             S_SYSCLK,
    input  logic             S_RESETN,
    input  spi_pkg::csmode_t i_mode,
    input  logic             i_in_trans,
    output logic             o_half_tick,
    output logic             o_spi_sck,
    output logic             o_spi_mosi,
    input  logic             i_spi_miso,
    spi_char_if.eng          chr
);
    logic [3:0] presc;
    logic       busy;
    logic [3:0] hcnt;     // sck half period within the character
    logic       sck_q;
    logic [7:0] tx_sh;
    logic [7:0] rx_sh;
    logic [7:0] rx_next;
    logic       lead_edge;
    logic       do_shift;
    logic       do_sample;

    // baud phase restarts whenever the frame clock stops
    assign o_half_tick = i_in_trans && (presc == i_mode.pm);

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            presc <= '0;
        end else if (!i_in_trans || o_half_tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 4'd1;
        end
    end

    assign lead_edge = ~hcnt[0];
    // cp=0 samples on the leading edge, cp=1 on the trailing one
    assign do_sample = busy && o_half_tick && (lead_edge ^ i_mode.cp);
    assign do_shift  = busy && o_half_tick &&
                       (i_mode.cp ? (lead_edge && (hcnt != 4'd0)) : !lead_edge);

    assign rx_next = i_mode.rev ? {rx_sh[6:0], i_spi_miso} : {i_spi_miso, rx_sh[7:1]};

    assign chr.done    = busy && o_half_tick && (hcnt == 4'hf);
    assign chr.rx_byte = i_mode.cp ? rx_next : rx_sh; // cp=1 takes its last bit on done

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            busy  <= 1'b0;
            hcnt  <= '0;
            sck_q <= 1'b0;
        end else if (chr.start) begin
            busy  <= 1'b1;
            hcnt  <= '0;
            sck_q <= i_mode.ci;
        end else if (busy && o_half_tick) begin
            hcnt  <= hcnt + 4'd1;
            sck_q <= ~sck_q;
            if (hcnt == 4'hf) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (chr.start) begin
            tx_sh <= chr.tx_byte;
        end else if (do_shift) begin
            tx_sh <= i_mode.rev ? {tx_sh[6:0], 1'b0} : {1'b0, tx_sh[7:1]};
        end
        if (do_sample) begin
            rx_sh <= rx_next;
        end
    end

    assign o_spi_sck  = busy ? sck_q : i_mode.ci;
    assign o_spi_mosi = busy && (i_mode.rev ? tx_sh[7] : tx_sh[0]); // idles low

endmodule

// File: src/spi_char_if.sv
`timescale 1ns/1ps

// one 8-bit character between sequencer and bit engine
interface spi_char_if;
    logic       start;   // tx_byte valid with it
    logic [7:0] tx_byte;
    logic       done;    // rx_byte valid with it
    logic [7:0] rx_byte;

    modport seq (
        output start,
        output tx_byte,
        input  done,
        input  rx_byte
    );

    modport eng (
        input  start,
        input  tx_byte,
        output done,
        output rx_byte
    );
endinterface

// File: src/spi_frame_ctrl.sv
`timescale 1ns/1ps

module spi_frame_ctrl #(
    parameter int NCS = 4
) (
    input  logic                          S_SYSCLK,
    input  logic                          S_RESETN,
    input  spi_pkg::csmode_t              i_mode,
    input  logic [1:0]                    i_cs_idx,
    input  logic [spi_pkg::TRANLEN_W-1:0] i_tranlen,
    input  logic                          i_frame_start,
    output logic                          o_frame_busy,
    output logic                          o_frame_done,
    input  logic                          i_half_tick,
    input  logic [spi_pkg::DATA_W-1:0]    i_tx_head,
    input  logic                          i_tx_empty,
    output logic                          o_tx_pop,
    output logic                          o_rx_push,
    output logic [spi_pkg::DATA_W-1:0]    o_rx_wdata,
    output logic [NCS-1:0]                o_spi_sel,
    output logic                          o_in_trans,
    spi_char_if.seq                       chr
);
    import spi_pkg::*;

    frame_state_e      state;
    logic [3:0]        dly_cnt;
    logic [TRANLEN_W:0] iss_cnt;  // characters started so far
    logic [1:0]        pos_q;     // byte lane of the character in flight
    logic [1:0]        tx_pos;
    logic [DATA_W-1:0] asm_q;     // rx word being assembled
    logic              sel_act;
    logic              more;
    logic              dly_zero;

    assign more     = (iss_cnt <= {1'b0, i_tranlen});
    assign dly_zero = (dly_cnt == 4'd0);
    assign tx_pos   = chr.done ? pos_q + 2'd1 : pos_q;

    always_comb begin
        chr.start = 1'b0;
        case (state)
            BEF_WAIT:  chr.start = i_half_tick && dly_zero && !i_tx_empty;
            DATA_WAIT: chr.start = !i_tx_empty;
            IN_TRANS:  chr.start = chr.done && more && !i_tx_empty; // back to back
            default:   ;
        endcase
    end

    assign chr.tx_byte = i_tx_head[{tx_pos, 3'b000} +: 8];

    // head is latched by the engine at start, so the word can go now
    assign o_tx_pop = chr.start && ((tx_pos == 2'd3) || (iss_cnt == {1'b0, i_tranlen}));

    always_comb begin
        o_rx_wdata = asm_q;
        o_rx_wdata[{pos_q, 3'b000} +: 8] = chr.rx_byte;
    end

    assign o_rx_push = chr.done && ((pos_q == 2'd3) || !more); // fifo drops it if full

    assign o_frame_busy = (state != IDLE);
    assign o_in_trans   = (state == BEF_WAIT) || (state == IN_TRANS) || (state == AFT_WAIT);

    always_comb begin
        for (int i = 0; i < NCS; i++) begin
            o_spi_sel[i] = i_mode.pol ^ (sel_act && (i_cs_idx == 2'(i)));
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            state        <= IDLE;
            dly_cnt      <= '0;
            iss_cnt      <= '0;
            pos_q        <= '0;
            sel_act      <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= 1'b0;
            if (chr.start) begin
                iss_cnt <= iss_cnt + 1'b1;
            end
            if (chr.done) begin
                pos_q <= pos_q + 2'd1;
            end
            case (state)
                IDLE: begin
                    if (i_frame_start) begin
                        state   <= BEF_WAIT;
                        sel_act <= 1'b1;
                        dly_cnt <= i_mode.csbef;
                        iss_cnt <= '0;
                        pos_q   <= '0;
                    end
                end
                BEF_WAIT: begin
                    if (i_half_tick) begin
                        if (!dly_zero) begin
                            dly_cnt <= dly_cnt - 4'd1;
                        end else begin
                            state <= chr.start ? IN_TRANS : DATA_WAIT;
                        end
                    end
                end
                DATA_WAIT: begin
                    if (chr.start) begin
                        state <= IN_TRANS;
                    end
                end
                IN_TRANS: begin
                    if (chr.done) begin
                        if (!more) begin
                            state   <= AFT_WAIT;
                            dly_cnt <= i_mode.csaft;
                        end else if (!chr.start) begin
                            state <= DATA_WAIT; // tx fifo ran dry
                        end
                    end
                end
                AFT_WAIT: begin
                    if (i_half_tick) begin
                        if (!dly_zero) begin
                            dly_cnt <= dly_cnt - 4'd1;
                        end else begin
                            state        <= IDLE;
                            sel_act      <= 1'b0;
                            o_frame_done <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (state == IDLE) begin
            asm_q <= '0;
        end else if (chr.done) begin
            asm_q <= o_rx_push ? '0 : o_rx_wdata; // zero pad the next word
        end
    end

endmodule

// File: src/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top #(
    parameter int NCS          = 4,
    parameter int TXFIFO_DEPTH = 4,
    parameter int RXFIFO_DEPTH = 4
) (
    input  logic                       S_SYSCLK,
    input  logic                       S_RESETN,
    input  logic [spi_pkg::ADDR_W-1:0] i_awaddr,
    input  logic [spi_pkg::DATA_W-1:0] i_wdata,
    input  logic [3:0]                 i_wstrb,
    input  logic                       i_reg_wen,
    input  logic [spi_pkg::ADDR_W-1:0] i_araddr,
    input  logic                       i_reg_rden,
    output logic [spi_pkg::DATA_W-1:0] o_rdata,
    output logic                       o_interrupt,
    output logic                       o_spi_sck,
    output logic                       o_spi_mosi,
    input  logic                       i_spi_miso,
    output logic [NCS-1:0]             o_spi_sel
);
    import spi_pkg::*;

    csmode_t              mode;
    logic [1:0]           cs_idx;
    logic [TRANLEN_W-1:0] tranlen;
    logic                 enable;
    logic                 frame_start;
    logic                 frame_busy;
    logic                 frame_done;
    logic                 half_tick;
    logic                 in_trans;
    logic                 tx_push;
    logic                 tx_pop;
    logic                 tx_full;
    logic                 tx_empty;
    logic [DATA_W-1:0]    tx_wdata;
    logic [DATA_W-1:0]    tx_head;
    logic                 rx_push;
    logic                 rx_pop;
    logic                 rx_full;
    logic                 rx_empty;
    logic [DATA_W-1:0]    rx_wdata;
    logic [DATA_W-1:0]    rx_head;

    spi_char_if chr_if ();

    spi_regs #(.NCS(NCS)) u_regs (
        .S_SYSCLK      (S_SYSCLK),
        .S_RESETN      (S_RESETN),
        .i_awaddr      (i_awaddr),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .i_reg_wen     (i_reg_wen),
        .i_araddr      (i_araddr),
        .i_reg_rden    (i_reg_rden),
        .o_rdata       (o_rdata),
        .o_interrupt   (o_interrupt),
        .o_mode        (mode),
        .o_cs_idx      (cs_idx),
        .o_tranlen     (tranlen),
        .o_enable      (enable),
        .o_frame_start (frame_start),
        .i_frame_busy  (frame_busy),
        .i_frame_done  (frame_done),
        .o_tx_push     (tx_push),
        .o_tx_wdata    (tx_wdata),
        .i_tx_full     (tx_full),
        .i_tx_empty    (tx_empty),
        .o_rx_pop      (rx_pop),
        .i_rx_head     (rx_head),
        .i_rx_full     (rx_full),
        .i_rx_empty    (rx_empty)
    );

    // both fifos are flushed while the block is disabled
    spi_word_fifo #(.DEPTH(TXFIFO_DEPTH), .WIDTH(DATA_W)) u_txfifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_flush  (!enable),
        .i_push   (tx_push),
        .i_wdata  (tx_wdata),
        .i_pop    (tx_pop),
        .o_rdata  (tx_head),
        .o_full   (tx_full),
        .o_empty  (tx_empty)
    );

    spi_word_fifo #(.DEPTH(RXFIFO_DEPTH), .WIDTH(DATA_W)) u_rxfifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_flush  (!enable),
        .i_push   (rx_push),
        .i_wdata  (rx_wdata),
        .i_pop    (rx_pop),
        .o_rdata  (rx_head),
        .o_full   (rx_full),
        .o_empty  (rx_empty)
    );

    spi_frame_ctrl #(.NCS(NCS)) u_frame (
        .S_SYSCLK      (S_SYSCLK),
        .S_RESETN      (S_RESETN),
        .i_mode        (mode),
        .i_cs_idx      (cs_idx),
        .i_tranlen     (tranlen),
        .i_frame_start (frame_start),
        .o_frame_busy  (frame_busy),
        .o_frame_done  (frame_done),
        .i_half_tick   (half_tick),
        .i_tx_head     (tx_head),
        .i_tx_empty    (tx_empty),
        .o_tx_pop      (tx_pop),
        .o_rx_push     (rx_push),
        .o_rx_wdata    (rx_wdata),
        .o_spi_sel     (o_spi_sel),
        .o_in_trans    (in_trans),
        .chr           (chr_if.seq)
    );

    spi_bit_engine u_engine (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .i_mode      (mode),
        .i_in_trans  (in_trans),
        .o_half_tick (half_tick),
        .o_spi_sck   (o_spi_sck),
        .o_spi_mosi  (o_spi_mosi),
        .i_spi_miso  (i_spi_miso),
        .chr         (chr_if.eng)
    );

endmodule

// File: src/spi_pkg.sv
package spi_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 8;
    localparam int TRANLEN_W = 16;

    typedef enum logic [ADDR_W-1:0] {
        SPMODE  = 8'h00,
        SPIE    = 8'h04,
        SPIM    = 8'h08,
        SPCOM   = 8'h0C,
        SPITF   = 8'h10,
        SPIRF   = 8'h14,
        CSMODE0 = 8'h20,
        CSMODE1 = 8'h24,
        CSMODE2 = 8'h28,
        CSMODE3 = 8'h2C
    } reg_addr_e;

    // per chip-select mode word
    typedef struct packed {
        logic       ci;     // sck idle level
        logic       cp;
        logic       rev;    // 1 = msb first
        logic       pol;    // 1 = select active low
        logic [3:0] pm;     // half period is pm+1 clocks
        logic [3:0] csbef;
        logic [3:0] csaft;
    } csmode_t;

    localparam int CSM_CI       = 31;
    localparam int CSM_CP       = 30;
    localparam int CSM_REV      = 29;
    localparam int CSM_POL      = 28;
    localparam int CSM_PM_LO    = 16;
    localparam int CSM_CSBEF_LO = 12;
    localparam int CSM_CSAFT_LO = 8;

    localparam int SPCOM_CS_LO = 30; // tranlen sits at 15:0
    localparam int SPMODE_EN   = 31;

    localparam int SPIE_TXE = 0;
    localparam int SPIE_TNF = 1;
    localparam int SPIE_RNE = 2;
    localparam int SPIE_RXF = 3;
    localparam int SPIE_DON = 4;
    localparam int SPIE_W   = 5;

    typedef enum logic [2:0] {
        IDLE,
        BEF_WAIT,
        DATA_WAIT,
        IN_TRANS,
        AFT_WAIT
    } frame_state_e;

    function automatic csmode_t word_to_csmode(input logic [DATA_W-1:0] w);
        csmode_t m;
        m.ci    = w[CSM_CI];
        m.cp    = w[CSM_CP];
        m.rev   = w[CSM_REV];
        m.pol   = w[CSM_POL];
        m.pm    = w[CSM_PM_LO +: 4];
        m.csbef = w[CSM_CSBEF_LO +: 4];
        m.csaft = w[CSM_CSAFT_LO +: 4];
        return m;
    endfunction

    function automatic logic [DATA_W-1:0] csmode_to_word(input csmode_t m);
        logic [DATA_W-1:0] w;
        w                      = '0; // unused bits read as zero
        w[CSM_CI]              = m.ci;
        w[CSM_CP]              = m.cp;
        w[CSM_REV]             = m.rev;
        w[CSM_POL]             = m.pol;
        w[CSM_PM_LO +: 4]      = m.pm;
        w[CSM_CSBEF_LO +: 4]   = m.csbef;
        w[CSM_CSAFT_LO +: 4]   = m.csaft;
        return w;
    endfunction

endpackage

// File: src/spi_regs.sv
`timescale 1ns/1ps

module spi_regs #(
    parameter int NCS = 4
) (
    input  logic                          S_SYSCLK,
    input  logic                          S_RESETN,
    input  logic [spi_pkg::ADDR_W-1:0]    i_awaddr,
    input  logic [spi_pkg::DATA_W-1:0]    i_wdata,
    input  logic [3:0]                    i_wstrb,
    input  logic                          i_reg_wen,
    input  logic [spi_pkg::ADDR_W-1:0]    i_araddr,
    input  logic                          i_reg_rden,
    output logic [spi_pkg::DATA_W-1:0]    o_rdata,
    output logic                          o_interrupt,
    output spi_pkg::csmode_t              o_mode,
    output logic [1:0]                    o_cs_idx,
    output logic [spi_pkg::TRANLEN_W-1:0] o_tranlen,
    output logic                          o_enable,
    output logic                          o_frame_start,
    input  logic                          i_frame_busy,
    input  logic                          i_frame_done,
    output logic                          o_tx_push,
    output logic [spi_pkg::DATA_W-1:0]    o_tx_wdata,
    input  logic                          i_tx_full,
    input  logic                          i_tx_empty,
    output logic                          o_rx_pop,
    input  logic [spi_pkg::DATA_W-1:0]    i_rx_head,
    input  logic                          i_rx_full,
    input  logic                          i_rx_empty
);
    import spi_pkg::*;

    logic                 en_q;
    logic [SPIE_W-1:0]    spim_q;
    logic [SPIE_W-1:0]    spie_q;
    logic [1:0]           cs_q;
    logic [TRANLEN_W-1:0] len_q;
    csmode_t              mode_q [NCS];
    logic                 wr_full;

    assign wr_full = i_reg_wen && (i_wstrb == 4'hf); // only whole words are taken

    assign o_enable    = en_q;
    assign o_cs_idx    = cs_q;
    assign o_tranlen   = len_q;
    assign o_mode      = (int'(cs_q) < NCS) ? mode_q[cs_q] : '0;
    assign o_interrupt = |(spim_q & spie_q);

    assign o_tx_push  = wr_full && (i_awaddr == SPITF) && en_q && !i_tx_full;
    assign o_tx_wdata = i_wdata;
    assign o_rx_pop   = i_reg_rden && (i_araddr == SPIRF) && !i_rx_empty;

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            en_q             <= 1'b0;
            spim_q           <= '0;
            cs_q             <= '0;
            len_q            <= '0;
            o_frame_start    <= 1'b0;
            spie_q           <= '0;
            spie_q[SPIE_TXE] <= 1'b1;
            spie_q[SPIE_TNF] <= 1'b1;
            for (int i = 0; i < NCS; i++) begin
                mode_q[i] <= '0;
            end
        end else begin
            o_frame_start <= 1'b0;
            // fifo levels lag by one clock
            spie_q[SPIE_TXE] <= i_tx_empty;
            spie_q[SPIE_TNF] <= !i_tx_full;
            spie_q[SPIE_RNE] <= !i_rx_empty;
            spie_q[SPIE_RXF] <= i_rx_full;
            if (wr_full) begin
                case (i_awaddr)
                    SPMODE: en_q <= i_wdata[SPMODE_EN];
                    SPIE: begin
                        if (i_wdata[SPIE_DON]) begin
                            spie_q[SPIE_DON] <= 1'b0;
                        end
                    end
                    SPIM: spim_q <= i_wdata[SPIE_W-1:0];
                    SPCOM: begin
                        cs_q  <= i_wdata[SPCOM_CS_LO +: 2];
                        len_q <= i_wdata[TRANLEN_W-1:0];
                        // no new start while a frame is busy
                        o_frame_start <= en_q && !i_frame_busy && !o_frame_start;
                    end
                    CSMODE0, CSMODE1, CSMODE2, CSMODE3: begin
                        if (int'(i_awaddr[3:2]) < NCS) begin
                            mode_q[i_awaddr[3:2]] <= word_to_csmode(i_wdata);
                        end
                    end
                    default: ;
                endcase
            end
            if (i_frame_done) begin
                spie_q[SPIE_DON] <= 1'b1; // new event beats a clear
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        case (i_araddr)
            SPMODE: o_rdata[SPMODE_EN]   = en_q;
            SPIE:   o_rdata[SPIE_W-1:0] = spie_q;
            SPIM:   o_rdata[SPIE_W-1:0] = spim_q;
            SPCOM: begin
                o_rdata[SPCOM_CS_LO +: 2]  = cs_q;
                o_rdata[TRANLEN_W-1:0]     = len_q;
            end
            SPIRF:  o_rdata = i_rx_head;
            CSMODE0, CSMODE1, CSMODE2, CSMODE3: begin
                if (int'(i_araddr[3:2]) < NCS) begin
                    o_rdata = csmode_to_word(mode_q[i_araddr[3:2]]);
                end
            end
            default: ;
        endcase
    end

endmodule

// File: src/spi_word_fifo.sv
`timescale 1ns/1ps

module spi_word_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             S_SYSCLK,
    input  logic             S_RESETN,
    input  logic             i_flush,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_wdata,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_rdata,
    output logic             o_full,
    output logic             o_empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_full  = (count == (AW+1)'(DEPTH));
    assign o_empty = (count == '0);
    assign o_rdata = mem[rd_ptr];   // head word

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

endmodule

// File: test/spi_stim.txt
# name cs ci cp rev pol pm csbef csaft nchar extra irq | tx0 tx1 tx2 tx3 | rx0 rx1 rx2 rx3
# decimal fields then hex words; extra pushes one word into a full fifo, irq unmasks DON
mode0_word    0 0 0 1 0 1  0  0  4  0 1 a5c30f1e 00000000 00000000 00000000 a5c30f1e 00000000 00000000 00000000
mode1_partial 1 0 1 0 0 2  1  2  3  0 0 12c0ffee 00000000 00000000 00000000 00c0ffee 00000000 00000000 00000000
mode2_pol_low 2 1 0 1 1 0  3  1  8  0 1 deadbeef 0badf00d 00000000 00000000 deadbeef 0badf00d 00000000 00000000
mode3_lsb     3 1 1 0 1 3  0  0  5  0 0 13579bdf 2468ace0 00000000 00000000 13579bdf 000000e0 00000000 00000000
slow_clock    0 1 1 1 0 15 2  3  2  0 1 cafe1234 00000000 00000000 00000000 00001234 00000000 00000000 00000000
fill_ovf_cp0  1 0 0 0 1 1  0  1  16 1 1 01234567 89abcdef fedcba98 76543210 01234567 89abcdef fedcba98 76543210
single_char   2 0 1 1 0 0  0  0  1  0 0 ffffff81 00000000 00000000 00000000 00000081 00000000 00000000 00000000
twelve_chars  3 0 0 0 0 4  5  5  12 0 1 a1b2c3d4 e5f60718 293a4b5c 00000000 a1b2c3d4 e5f60718 293a4b5c 00000000
seven_chars   0 1 0 0 1 1  1  1  7  0 0 55aa33cc 0f0ff0f0 00000000 00000000 55aa33cc 000ff0f0 00000000 00000000
fill_ovf_cp1  2 1 1 1 0 2  0  0  16 1 0 00ff00ff 80402010 08040201 fedcba98 00ff00ff 80402010 08040201 fedcba98
max_delays    1 0 1 1 1 0  15 15 6  0 1 c3c3a5a5 12345a3c 00000000 00000000 c3c3a5a5 00005a3c 00000000 00000000

// File: test/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;
    import spi_pkg::*;

    localparam int NCS           = 4;
    localparam int TXFIFO_DEPTH  = 4;
    localparam int RXFIFO_DEPTH  = 4;
    localparam int FRAME_TIMEOUT = 20000; // clocks

    logic              S_SYSCLK;
    logic              S_RESETN;
    logic [ADDR_W-1:0] i_awaddr;
    logic [DATA_W-1:0] i_wdata;
    logic [3:0]        i_wstrb;
    logic              i_reg_wen;
    logic [ADDR_W-1:0] i_araddr;
    logic              i_reg_rden;
    logic [DATA_W-1:0] o_rdata;
    logic              o_interrupt;
    logic              o_spi_sck;
    logic              o_spi_mosi;
    logic [NCS-1:0]    o_spi_sel;

    string       tname;
    int          test_errs;
    int          n_tests;
    int          n_failed;
    int          cs, ci, cp, rev, pol, pm;
    int          csbef, csaft, nchar, extra, irq;
    logic [31:0] tx_words [4];
    logic [31:0] rx_words [4];

    spi_master_top #(
        .NCS          (NCS),
        .TXFIFO_DEPTH (TXFIFO_DEPTH),
        .RXFIFO_DEPTH (RXFIFO_DEPTH)
    ) uut (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .i_awaddr    (i_awaddr),
        .i_wdata     (i_wdata),
        .i_wstrb     (i_wstrb),
        .i_reg_wen   (i_reg_wen),
        .i_araddr    (i_araddr),
        .i_reg_rden  (i_reg_rden),
        .o_rdata     (o_rdata),
        .o_interrupt (o_interrupt),
        .o_spi_sck   (o_spi_sck),
        .o_spi_mosi  (o_spi_mosi),
        .i_spi_miso  (o_spi_mosi),  // external loopback
        .o_spi_sel   (o_spi_sel)
    );

    initial begin
        S_SYSCLK = 1'b0;
        forever #4 S_SYSCLK = ~S_SYSCLK;
    end

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s: %s expected %h actual %h", tname, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic random_gap;
        repeat ($urandom % 3) @(negedge S_SYSCLK);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        random_gap();
        @(negedge S_SYSCLK);
        i_awaddr  = addr;
        i_wdata   = data;
        i_wstrb   = 4'hf;
        i_reg_wen = 1'b1;
        @(negedge S_SYSCLK);
        i_reg_wen = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic pop,
                            output logic [31:0] data);
        random_gap();
        @(negedge S_SYSCLK);
        i_araddr   = addr;
        i_reg_rden = pop;
        #2 data = o_rdata; // pop lands on the next rising edge
        @(negedge S_SYSCLK);
        i_reg_rden = 1'b0;
    endtask

    task automatic check_status(input logic [4:0] mask, input logic [4:0] exp);
        logic [31:0] v;
        repeat (2) @(negedge S_SYSCLK); // spie trails the fifos
        read_reg(SPIE, 1'b0, v);
        compare_value("spie status", 32'(exp & mask), v & 32'(mask));
    endtask

    task automatic finish_test;
        n_tests++;
        if (test_errs == 0) begin
            $display("PASS %s", tname);
        end else begin
            $display("FAIL %s (%0d errors)", tname, test_errs);
            n_failed++;
        end
    endtask

    task automatic run_frame_test;
        logic [31:0]    mode_word;
        logic [31:0]    spcom_word;
        logic [31:0]    v;
        logic [NCS-1:0] idle_sel;
        logic [NCS-1:0] cs_bit;
        logic           prev_sck;
        logic           sel_bad;
        logic           don_seen;
        logic           irq_early;
        int             nwords;
        int             npush;
        int             edges;
        int             rx_cnt;

        nwords     = (nchar + 3) / 4;
        npush      = nwords + extra;
        mode_word  = {ci[0], cp[0], rev[0], pol[0], 8'h00, pm[3:0], csbef[3:0],
                      csaft[3:0], 8'h00};
        spcom_word = {cs[1:0], 14'h0, 16'(nchar - 1)};
        idle_sel   = {NCS{pol[0]}};
        cs_bit     = '0;
        cs_bit[cs] = 1'b1;

        write_reg(SPMODE, 32'h0);
        write_reg(SPIM, irq ? 32'h10 : 32'h0);
        write_reg(8'(32'h20 + 4 * cs), mode_word);
        read_reg(8'(32'h20 + 4 * cs), 1'b0, v);
        compare_value("csmode readback", mode_word, v);
        write_reg(SPCOM, spcom_word); // block is off, only stored
        compare_value("sck before frame", ci, o_spi_sck);
        compare_value("select before frame", idle_sel, o_spi_sel);

        write_reg(SPMODE, 32'h8000_0000);
        check_status(5'b00111, 5'b00011);
        for (int k = 0; k < npush; k++) begin
            write_reg(SPITF, (k < nwords) ? tx_words[k] : 32'hdeadc0de);
        end
        check_status(5'b00111, 5'((npush < TXFIFO_DEPTH) ? 2 : 0));

        write_reg(SPCOM, spcom_word);
        i_araddr  = SPIE;
        prev_sck  = o_spi_sck;
        edges     = 0;
        sel_bad   = 1'b0;
        don_seen  = 1'b0;
        irq_early = 1'b0;
        for (int c = 0; c < FRAME_TIMEOUT && !don_seen; c++) begin
            @(negedge S_SYSCLK);
            if (o_spi_sck !== prev_sck) begin
                edges++;
                if (o_spi_sel[cs] === pol[0]) sel_bad = 1'b1; // clocking while deselected
            end
            if (((o_spi_sel ^ idle_sel) & ~cs_bit) != '0) sel_bad = 1'b1;
            prev_sck = o_spi_sck;
            don_seen = o_rdata[SPIE_DON];
            if (!don_seen && o_interrupt) irq_early = 1'b1;
        end
        assert (don_seen) else begin
            $display("%s: frame did not signal done within %0d clocks", tname, FRAME_TIMEOUT);
            test_errs++;
        end
        assert (!sel_bad) else begin
            $display("%s: chip select at the wrong level during the frame", tname);
            test_errs++;
        end
        assert (!irq_early) else begin
            $display("%s: interrupt raised before the frame ended", tname);
            test_errs++;
        end
        compare_value("sck edges", 16 * nchar, edges);
        compare_value("interrupt at done", irq, o_interrupt);
        compare_value("sck after frame", ci, o_spi_sck);
        compare_value("select after frame", idle_sel, o_spi_sel);
        compare_value("mosi after frame", 0, o_spi_mosi);
        check_status(5'b11100, {1'b1, nwords == RXFIFO_DEPTH, 1'b1, 2'b00});

        write_reg(SPIE, 32'h10); // w1c on don
        check_status(5'b10000, 5'b00000);
        compare_value("interrupt after clear", 0, o_interrupt);

        rx_cnt = 0;
        read_reg(SPIE, 1'b0, v);
        while (v[SPIE_RNE] && rx_cnt < 8) begin
            read_reg(SPIRF, 1'b1, v);
            if (rx_cnt < 4) begin
                compare_value($sformatf("rx word %0d", rx_cnt), rx_words[rx_cnt], v);
            end
            rx_cnt++;
            read_reg(SPIE, 1'b0, v);
        end
        assert (rx_cnt < 8) else begin
            $display("%s: receive fifo never ran empty", tname);
            test_errs++;
        end
        compare_value("rx word count", nwords, rx_cnt);

        // leftover tx word must vanish when the block is disabled
        write_reg(SPITF, 32'h5a5a5a5a);
        check_status(5'b00001, 5'b00000);
        write_reg(SPMODE, 32'h0);
        check_status(5'b00111, 5'b00011);
    endtask

    initial begin
        int    fd;
        int    nf;
        string line;

        void'($urandom(81095));
        S_RESETN   = 1'b0;
        i_awaddr   = '0;
        i_wdata    = '0;
        i_wstrb    = '0;
        i_reg_wen  = 1'b0;
        i_araddr   = '0;
        i_reg_rden = 1'b0;
        n_tests    = 0;
        n_failed   = 0;
        repeat (3) @(negedge S_SYSCLK);
        S_RESETN = 1'b1;

        tname     = "reset_levels";
        test_errs = 0;
        compare_value("sck after reset", 0, o_spi_sck);
        compare_value("select after reset", 0, o_spi_sel);
        compare_value("mosi after reset", 0, o_spi_mosi);
        compare_value("interrupt after reset", 0, o_interrupt);
        check_status(5'b11111, 5'b00011);
        finish_test();

        fd = $fopen("test/spi_stim.txt", "r");
        assert (fd != 0) else begin
            $display("could not open test/spi_stim.txt");
            n_tests++;
            n_failed++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    nf = $sscanf(line,
                        "%s %d %d %d %d %d %d %d %d %d %d %d %h %h %h %h %h %h %h %h",
                        tname, cs, ci, cp, rev, pol, pm, csbef, csaft, nchar, extra, irq,
                        tx_words[0], tx_words[1], tx_words[2], tx_words[3],
                        rx_words[0], rx_words[1], rx_words[2], rx_words[3]);
                    test_errs = 0;
                    if (nf == 20) begin
                        run_frame_test();
                    end else begin
                        $display("stim line could not be parsed: %s", line);
                        test_errs++;
                    end
                    finish_test();
                end
            end
            $fclose(fd);
        end

        $display("tests run: %0d, passed: %0d, failed: %0d",
                 n_tests, n_tests - n_failed, n_failed);
        if (n_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
